// File: hdl/robotSense_cfg.svh
`ifndef ROBOT_SENSE_CFG_SVH
`define ROBOT_SENSE_CFG_SVH

// ====================
// datapath sizes
// ====================

// register and count width
`define WORD_WIDTH 16

// encoder axes measured
`define AXIS_COUNT 7

// ====================
// timing
// ====================

// clock cycles per window register unit
`define WINDOW_UNIT 100
// window after reset, 500000 cycles
`define WINDOW_DEFAULT 5000
// turret ticks a dropped sign may last
`define HOLD_TICKS 20
// flops on every pin input
`define SYNC_STAGES 2

// direction polarity per axis, bit 0 is propulsion left
// propulsion right and odometry left are mounted mirrored
`define DIR_INVERT_MASK 7'b0000110

`endif

// File: hdl/robotSensePkg.sv
`include "robotSense_cfg.svh"

package robotSensePkg;

	// encoder axes, in speed register order
	typedef enum logic [2:0] {
		AXIS_PROP_LEFT,
		AXIS_PROP_RIGHT,
		AXIS_ODO_LEFT,
		AXIS_ODO_RIGHT,
		AXIS_GRIPPER,
		AXIS_RAKE_LEFT,
		AXIS_RAKE_RIGHT
	} axisIdx_t;

	// host word addresses
	typedef enum logic [3:0] {
		REG_STATUS       = 4'd0,
		REG_SPEED0       = 4'd1,
		REG_SPEED1       = 4'd2,
		REG_SPEED2       = 4'd3,
		REG_SPEED3       = 4'd4,
		REG_SPEED4       = 4'd5,
		REG_SPEED5       = 4'd6,
		REG_SPEED6       = 4'd7,
		REG_BEACON_START = 4'd8,
		REG_BEACON_END   = 4'd9,
		REG_CONFIG       = 4'd10,
		REG_WINDOW       = 4'd11
	} regAddr_t;

	// laser sign reception
	typedef enum logic [1:0] {
		WAIT,
		RECEPTION,
		GLITCH
	} beaconState_t;

	typedef struct packed {
		logic phaseA;
		logic phaseB;
	} encoderPins_t;

	typedef struct packed {
		logic [`WORD_WIDTH-1:0] speed;
		logic                   forward;
	} speedSample_t;

	typedef struct packed {
		logic [`WORD_WIDTH-1:0] startAngle;
		logic [`WORD_WIDTH-1:0] endAngle;
		logic                   turn;
	} beaconResult_t;

	typedef struct packed {
		logic left;
		logic right;
		logic gripper;
		logic rakeLeft;
		logic rakeRight;
	} limitSwitches_t;

	typedef struct packed {
		logic                   strobe;
		regAddr_t               addr;
		logic [`WORD_WIDTH-1:0] data;
	} regWrite_t;

	typedef struct packed {
		logic [1:0]             intEnable;
		logic [1:0]             auxOut;
		logic [`WORD_WIDTH-1:0] windowUnits;
	} robotConfig_t;

endpackage

// File: hdl/encoderChannel.sv
`timescale 1ns/1ps
`include "robotSense_cfg.svh"

module encoderChannel
	import robotSensePkg::*;
(
	input  logic         CLOCK_50,
	input  logic         reset,
	input  encoderPins_t pins,
	input  logic         invert,
	input  logic         windowEnd,
	output speedSample_t speed
);

	encoderPins_t syncPipe [`SYNC_STAGES];
	encoderPins_t lastPins;
	encoderPins_t pinsNow;
	encoderPins_t rise;
	// index 1 counts phase A, index 0 phase B, as in the struct bits
	logic [`WORD_WIDTH-1:0] edgeCount [2];
	logic [`WORD_WIDTH:0]   countSum;

	// ====================
	// pin sync and edges
	// ====================

	assign pinsNow = syncPipe[`SYNC_STAGES-1];
	assign rise = encoderPins_t'(pinsNow & ~lastPins);

	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			for (int s = 0; s < `SYNC_STAGES; s++) begin
				syncPipe[s] <= '0;
			end
			lastPins <= '0;
		end else begin
			syncPipe[0] <= pins;
			for (int s = 1; s < `SYNC_STAGES; s++) begin
				syncPipe[s] <= syncPipe[s-1];
			end
			lastPins <= pinsNow;
		end
	end

	// ====================
	// edge counters
	// ====================

	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			for (int c = 0; c < 2; c++) begin
				edgeCount[c] <= '0;
			end
		end else begin
			for (int c = 0; c < 2; c++) begin
				// new window starts, an edge on this very cycle is kept
				if (windowEnd)
					edgeCount[c] <= {{(`WORD_WIDTH-1){1'b0}}, rise[c]};
				else if (rise[c] && edgeCount[c] != '1)
					edgeCount[c] <= edgeCount[c] + 1'b1;
			end
		end
	end

	// 17 bit sum, no overflow before halving
	assign countSum = {1'b0, edgeCount[0]} + {1'b0, edgeCount[1]};

	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			speed <= '0;
		end else begin
			if (windowEnd)
				speed.speed <= countSum[`WORD_WIDTH:1];
			// quadrature direction from B level at A rise
			if (rise.phaseA)
				speed.forward <= pinsNow.phaseB ^ invert;
		end
	end

	// direction only moves right after a phase A rise
	forwardOnRise: assert property (@(posedge CLOCK_50) disable iff (reset)
		!$past(rise.phaseA) |-> $stable(speed.forward));

endmodule

// File: hdl/speedMeter.sv
`timescale 1ns/1ps
`include "robotSense_cfg.svh"

module speedMeter
	import robotSensePkg::*;
(
	input  logic                                  CLOCK_50,
	input  logic                                  reset,
	input  encoderPins_t [`AXIS_COUNT-1:0]        encoders,
	input  logic         [`WORD_WIDTH-1:0]        windowUnits,
	input  logic                                  windowRestart,
	output speedSample_t [`AXIS_COUNT-1:0]        speeds
);

	localparam logic [`AXIS_COUNT-1:0] invertMask = `DIR_INVERT_MASK;

	logic [`WORD_WIDTH-1:0] unitsEff;
	logic [31:0]            windowLength;
	logic [31:0]            cycleCount;
	logic                   windowEnd;

	// ====================
	// window timer
	// ====================

	// zero units would stall, run as one unit
	assign unitsEff = (windowUnits == '0) ? {{(`WORD_WIDTH-1){1'b0}}, 1'b1} : windowUnits;
	assign windowLength = 32'(unitsEff) * 32'(`WINDOW_UNIT);

	// >= so a shortened window ends at once
	assign windowEnd = (cycleCount >= windowLength - 32'd1);

	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset)
			cycleCount <= '0;
		else if (windowRestart || windowEnd)
			cycleCount <= '0;
		else
			cycleCount <= cycleCount + 32'd1;
	end

	// ====================
	// per axis counting
	// ====================

	for (genvar i = 0; i < `AXIS_COUNT; i++) begin : gAxis
		encoderChannel channel_i (
			.CLOCK_50  (CLOCK_50),
			.reset     (reset),
			.pins      (encoders[i]),
			.invert    (invertMask[i]),
			.windowEnd (windowEnd),
			.speed     (speeds[i])
		);
	end

	// window is at least one unit long
	windowEndSingle: assert property (@(posedge CLOCK_50) disable iff (reset)
		windowEnd |=> !windowEnd);

endmodule

// File: hdl/beaconCapture.sv
`timescale 1ns/1ps
`include "robotSense_cfg.svh"

module beaconCapture
	import robotSensePkg::*;
(
	input  logic          CLOCK_50,
	input  logic          reset,
	input  logic          sign,
	input  logic          sync,
	input  logic          turretTick,
	output beaconResult_t beacon
);

	localparam int holdWidth = $clog2(`HOLD_TICKS + 1);

	// bit 2 sign, bit 1 sync, bit 0 turret tick
	logic [2:0]             syncPipe [`SYNC_STAGES];
	logic [2:0]             inNow;
	logic [1:0]             lastEdge;
	logic                   signNow;
	logic                   syncRise;
	logic                   tickRise;
	logic [`WORD_WIDTH-1:0] angle;
	logic [`WORD_WIDTH-1:0] pendStart;
	logic [`WORD_WIDTH-1:0] pendEnd;
	logic [holdWidth-1:0]   holdCount;
	logic                   holdDone;
	beaconState_t           state;
	beaconState_t           nextState;

	// ====================
	// input sync
	// ====================

	assign inNow = syncPipe[`SYNC_STAGES-1];
	assign signNow = inNow[2];
	assign syncRise = inNow[1] & ~lastEdge[1];
	assign tickRise = inNow[0] & ~lastEdge[0];

	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			for (int s = 0; s < `SYNC_STAGES; s++) begin
				syncPipe[s] <= '0;
			end
			lastEdge <= '0;
		end else begin
			syncPipe[0] <= {sign, sync, turretTick};
			for (int s = 1; s < `SYNC_STAGES; s++) begin
				syncPipe[s] <= syncPipe[s-1];
			end
			lastEdge <= inNow[1:0];
		end
	end

	// turret angle, zero at sync
	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset)
			angle <= '0;
		else if (syncRise)
			angle <= '0;
		else if (tickRise)
			angle <= angle + 1'b1;
	end

	// ====================
	// reception fsm
	// ====================

	// last hold tick with sign still low
	assign holdDone = tickRise && (holdCount == holdWidth'(`HOLD_TICKS - 1));

	always_comb begin
		nextState = state;
		case (state)
			WAIT: begin
				if (signNow)
					nextState = RECEPTION;
			end
			RECEPTION: begin
				if (!signNow)
					nextState = GLITCH;
			end
			GLITCH: begin
				// short dropout, same reception
				if (signNow)
					nextState = RECEPTION;
				else if (holdDone)
					nextState = WAIT;
			end
			default: nextState = WAIT;
		endcase
	end

	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			state <= WAIT;
			holdCount <= '0;
			beacon <= '0;
		end else begin
			state <= nextState;
			// hold ticks restart on each new fall
			if (state == RECEPTION && nextState == GLITCH)
				holdCount <= '0;
			else if (state == GLITCH && tickRise)
				holdCount <= holdCount + 1'b1;
			// publish on end of reception
			if (state == GLITCH && nextState == WAIT) begin
				beacon.startAngle <= pendStart;
				beacon.endAngle <= pendEnd;
			end
			if (syncRise)
				beacon.turn <= ~beacon.turn;
		end
	end

	// pending angles, published only from GLITCH
	always_ff @(posedge CLOCK_50) begin
		if (state == WAIT && nextState == RECEPTION)
			pendStart <= angle;
		if (state == RECEPTION && nextState == GLITCH)
			pendEnd <= angle;
	end

	stateLegal: assert property (@(posedge CLOCK_50) disable iff (reset)
		state inside {WAIT, RECEPTION, GLITCH});

endmodule

// File: hdl/sensorRegs.sv
`timescale 1ns/1ps
`include "robotSense_cfg.svh"

module sensorRegs
	import robotSensePkg::*;
(
	input  logic                           CLOCK_50,
	input  logic                           reset,
	input  regWrite_t                      regWrite,
	input  regAddr_t                       regReadAddr,
	input  speedSample_t [`AXIS_COUNT-1:0] speeds,
	input  beaconResult_t                  beacon,
	input  limitSwitches_t                 limits,
	input  logic                           startCord,
	input  logic         [1:0]             keys,
	input  logic                           id,
	output logic         [`WORD_WIDTH-1:0] regReadData,
	output robotConfig_t                   robotConfig,
	output logic                           windowRestart,
	output logic                           int1,
	output logic                           int2
);

	// keys 8:7, cord 6, id 5, limit switches 4:0
	logic [8:0]             syncPipe [`SYNC_STAGES];
	logic [8:0]             pinsNow;
	limitSwitches_t         limitsSync;
	logic                   startSync;
	logic                   idSync;
	logic [1:0]             keysSync;
	logic [`WORD_WIDTH-1:0] statusWord;
	logic [`WORD_WIDTH-1:0] readWord;
	axisIdx_t               readAxis;

	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			for (int s = 0; s < `SYNC_STAGES; s++) begin
				syncPipe[s] <= '0;
			end
		end else begin
			syncPipe[0] <= {keys, startCord, id, limits};
			for (int s = 1; s < `SYNC_STAGES; s++) begin
				syncPipe[s] <= syncPipe[s-1];
			end
		end
	end

	assign pinsNow = syncPipe[`SYNC_STAGES-1];
	assign limitsSync = limitSwitches_t'(pinsNow[4:0]);
	assign idSync = pinsNow[5];
	assign startSync = pinsNow[6];
	assign keysSync = pinsNow[8:7];

	// ====================
	// config and window
	// ====================

	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			robotConfig.intEnable <= '0;
			robotConfig.auxOut <= '0;
			robotConfig.windowUnits <= `WORD_WIDTH'(`WINDOW_DEFAULT);
			windowRestart <= 1'b0;
		end else begin
			windowRestart <= regWrite.strobe && regWrite.addr == REG_WINDOW;
			if (regWrite.strobe && regWrite.addr == REG_CONFIG) begin
				robotConfig.intEnable <= regWrite.data[1:0];
				robotConfig.auxOut <= regWrite.data[5:4];
			end
			if (regWrite.strobe && regWrite.addr == REG_WINDOW)
				robotConfig.windowUnits <= regWrite.data;
		end
	end

	// key interrupts, idle high
	assign int1 = robotConfig.intEnable[0] ? keysSync[0] : 1'b1;
	assign int2 = robotConfig.intEnable[1] ? keysSync[1] : 1'b1;

	// ====================
	// status and reads
	// ====================

	assign statusWord = {
		beacon.turn, 1'b0, startSync,
		limitsSync.rakeRight, limitsSync.rakeLeft, limitsSync.gripper,
		limitsSync.right, limitsSync.left,
		speeds[AXIS_ODO_RIGHT].forward, speeds[AXIS_ODO_LEFT].forward,
		speeds[AXIS_GRIPPER].forward,
		speeds[AXIS_RAKE_RIGHT].forward, speeds[AXIS_RAKE_LEFT].forward,
		speeds[AXIS_PROP_RIGHT].forward, speeds[AXIS_PROP_LEFT].forward,
		idSync
	};

	// speed registers follow axis order from REG_SPEED0
	assign readAxis = axisIdx_t'(regReadAddr - REG_SPEED0);

	always_comb begin
		readWord = '0;
		case (regReadAddr)
			REG_STATUS: readWord = statusWord;
			REG_SPEED0, REG_SPEED1, REG_SPEED2, REG_SPEED3,
			REG_SPEED4, REG_SPEED5, REG_SPEED6: readWord = speeds[readAxis].speed;
			REG_BEACON_START: readWord = beacon.startAngle;
			REG_BEACON_END: readWord = beacon.endAngle;
			REG_CONFIG: readWord = {10'b0, robotConfig.auxOut, 2'b0, robotConfig.intEnable};
			REG_WINDOW: readWord = robotConfig.windowUnits;
			default: readWord = '0;
		endcase
	end

	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset)
			regReadData <= '0;
		else
			regReadData <= readWord;
	end

endmodule

// File: hdl/robotSenseTop.sv
`timescale 1ns/1ps
`include "robotSense_cfg.svh"

module robotSenseTop
	import robotSensePkg::*;
(
	input  logic                           CLOCK_50,
	input  logic                           reset,
	input  encoderPins_t [`AXIS_COUNT-1:0] encoders,
	input  logic                           beaconSign,
	input  logic                           beaconSync,
	input  logic                           turretA,
	input  limitSwitches_t                 limits,
	input  logic                           startCord,
	input  logic         [1:0]             keys,
	input  logic                           id,
	input  regWrite_t                      regWrite,
	input  regAddr_t                       regReadAddr,
	output logic         [`WORD_WIDTH-1:0] regReadData,
	output logic                           int1,
	output logic                           int2,
	output logic         [1:0]             auxOut
);

	speedSample_t [`AXIS_COUNT-1:0] speeds;
	beaconResult_t                  beacon;
	robotConfig_t                   robotConfig;
	logic                           windowRestart;

	// auxiliary pins straight from config
	assign auxOut = robotConfig.auxOut;

	speedMeter speedMeter_i (
		.CLOCK_50      (CLOCK_50),
		.reset         (reset),
		.encoders      (encoders),
		.windowUnits   (robotConfig.windowUnits),
		.windowRestart (windowRestart),
		.speeds        (speeds)
	);

	// turret ticks on encoder phase A
	beaconCapture beaconCapture_i (
		.CLOCK_50   (CLOCK_50),
		.reset      (reset),
		.sign       (beaconSign),
		.sync       (beaconSync),
		.turretTick (turretA),
		.beacon     (beacon)
	);

	sensorRegs sensorRegs_i (
		.CLOCK_50      (CLOCK_50),
		.reset         (reset),
		.regWrite      (regWrite),
		.regReadAddr   (regReadAddr),
		.speeds        (speeds),
		.beacon        (beacon),
		.limits        (limits),
		.startCord     (startCord),
		.keys          (keys),
		.id            (id),
		.regReadData   (regReadData),
		.robotConfig   (robotConfig),
		.windowRestart (windowRestart),
		.int1          (int1),
		.int2          (int2)
	);

endmodule

// File: dv/robotSenseTb.sv
`timescale 1ns/1ps
`include "robotSense_cfg.svh"

module robotSenseTb
	import robotSensePkg::*;
();

	localparam logic [`AXIS_COUNT-1:0] invertMask = `DIR_INVERT_MASK;
	localparam int speedRounds = 3;
	localparam int beaconRounds = 2;
	// test window of 4 units, beacon round is about 700 cycles
	localparam int windowCycles = 4 * `WINDOW_UNIT;
	localparam int beaconCycles = 700;
	localparam int timeoutLimit = 4 * (speedRounds * windowCycles + beaconRounds * beaconCycles)
		+ 1000;

	logic                           CLOCK_50;
	logic                           reset;
	encoderPins_t [`AXIS_COUNT-1:0] encoders;
	logic                           beaconSign;
	logic                           beaconSync;
	logic                           turretA;
	limitSwitches_t                 limits;
	logic                           startCord;
	logic [1:0]                     keys;
	logic                           id;
	regWrite_t                      regWrite;
	regAddr_t                       regReadAddr;
	logic [`WORD_WIDTH-1:0]         regReadData;
	logic                           int1;
	logic                           int2;
	logic [1:0]                     auxOut;

	// expected values and check strobes
	logic                   readPending;
	logic [`WORD_WIDTH-1:0] expWord;
	logic                   pinPending;
	logic                   expInt1;
	logic                   expInt2;
	logic [1:0]             expAux;
	// model of the status word inputs
	logic [`AXIS_COUNT-1:0] dirModel;
	logic                   turnModel;
	logic [31:0]            seed = 32'h6f88b202;
	int                     cycleNum = 0;
	int                     errorCount = 0;
	int                     checkCount = 0;

	robotSenseTop dut_i (
		.CLOCK_50    (CLOCK_50),
		.reset       (reset),
		.encoders    (encoders),
		.beaconSign  (beaconSign),
		.beaconSync  (beaconSync),
		.turretA     (turretA),
		.limits      (limits),
		.startCord   (startCord),
		.keys        (keys),
		.id          (id),
		.regWrite    (regWrite),
		.regReadAddr (regReadAddr),
		.regReadData (regReadData),
		.int1        (int1),
		.int2        (int2),
		.auxOut      (auxOut)
	);

	initial begin
		CLOCK_50 = 1'b0;
		forever #50 CLOCK_50 = ~CLOCK_50;
	end

	// ====================
	// checkers
	// ====================

	// read data lands one cycle after the address
	readCheck: assert property (@(posedge CLOCK_50) disable iff (reset)
		readPending |=> regReadData == expWord)
	else begin
		errorCount++;
		$display("ERR %0t regReadData (addr %0d) expected %h got %h",
			$time, $sampled(regReadAddr), $sampled(expWord), $sampled(regReadData));
	end

	int1Check: assert property (@(posedge CLOCK_50) disable iff (reset)
		pinPending |-> int1 == expInt1)
	else begin
		errorCount++;
		$display("ERR %0t int1 expected %b got %b", $time, expInt1, $sampled(int1));
	end

	int2Check: assert property (@(posedge CLOCK_50) disable iff (reset)
		pinPending |-> int2 == expInt2)
	else begin
		errorCount++;
		$display("ERR %0t int2 expected %b got %b", $time, expInt2, $sampled(int2));
	end

	auxCheck: assert property (@(posedge CLOCK_50) disable iff (reset)
		pinPending |-> auxOut == expAux)
	else begin
		errorCount++;
		$display("ERR %0t auxOut expected %b got %b", $time, expAux, $sampled(auxOut));
	end

	// run limit
	always @(posedge CLOCK_50) begin
		cycleNum <= cycleNum + 1;
		if (cycleNum >= timeoutLimit) begin
			$display("timeout: the run did not finish within %0d cycles", timeoutLimit);
			$display("checks %0d errors %0d", checkCount, errorCount);
			$display("tests failed");
			$finish;
		end
	end

	// ====================
	// helpers
	// ====================

	// lcg, upper bits only
	function automatic int randRange(int lo, int hi);
		seed = seed * 32'd1664525 + 32'd1013904223;
		return lo + int'((seed >> 8) % (hi - lo + 1));
	endfunction

	// status word as laid out in the register map
	function automatic logic [`WORD_WIDTH-1:0] expectedStatus();
		return {turnModel, 1'b0, startCord,
			limits.rakeRight, limits.rakeLeft, limits.gripper, limits.right, limits.left,
			dirModel[3], dirModel[2], dirModel[4], dirModel[6], dirModel[5],
			dirModel[1], dirModel[0], id};
	endfunction

	task automatic readReg(regAddr_t addr, logic [`WORD_WIDTH-1:0] expected);
		@(posedge CLOCK_50);
		regReadAddr <= addr;
		expWord <= expected;
		readPending <= 1'b1;
		@(posedge CLOCK_50);
		readPending <= 1'b0;
		// keep expWord steady through the check edge
		@(posedge CLOCK_50);
		checkCount++;
	endtask

	task automatic writeReg(regAddr_t addr, logic [`WORD_WIDTH-1:0] data);
		@(posedge CLOCK_50);
		regWrite <= '{strobe: 1'b1, addr: addr, data: data};
		@(posedge CLOCK_50);
		regWrite.strobe <= 1'b0;
	endtask

	task automatic checkPins(logic i1, logic i2, logic [1:0] aux);
		@(posedge CLOCK_50);
		expInt1 <= i1;
		expInt2 <= i2;
		expAux <= aux;
		pinPending <= 1'b1;
		@(posedge CLOCK_50);
		pinPending <= 1'b0;
		checkCount += 3;
	endtask

	// one 8 cycle pulse on a phase
	task automatic pulsePhase(int axis, logic onA);
		@(posedge CLOCK_50);
		if (onA)
			encoders[axis].phaseA <= 1'b1;
		else
			encoders[axis].phaseB <= 1'b1;
		repeat (4) @(posedge CLOCK_50);
		if (onA)
			encoders[axis].phaseA <= 1'b0;
		else
			encoders[axis].phaseB <= 1'b0;
		repeat (3) @(posedge CLOCK_50);
	endtask

	task automatic tickTurret(int count);
		repeat (count) begin
			@(posedge CLOCK_50);
			turretA <= 1'b1;
			repeat (4) @(posedge CLOCK_50);
			turretA <= 1'b0;
			repeat (3) @(posedge CLOCK_50);
		end
	endtask

	task automatic setSign(logic level);
		@(posedge CLOCK_50);
		beaconSign <= level;
		repeat (4) @(posedge CLOCK_50);
	endtask

	// ====================
	// tests
	// ====================

	task automatic speedRound();
		int axis;
		int nA;
		int nB;
		int v;
		int startCycle;
		axis = randRange(0, `AXIS_COUNT - 1);
		nA = randRange(1, 16);
		nB = randRange(1, 16);
		v = randRange(0, 1);
		startCycle = cycleNum;
		// new window starts with the write
		writeReg(REG_WINDOW, 16'd4);
		repeat (nB - v) pulsePhase(axis, 1'b0);
		// last B rise stays high as the direction level
		if (v) begin
			@(posedge CLOCK_50);
			encoders[axis].phaseB <= 1'b1;
			repeat (8) @(posedge CLOCK_50);
		end
		repeat (nA) pulsePhase(axis, 1'b1);
		dirModel[axis] = v[0] ^ invertMask[axis];
		// just past the end of the window
		while (cycleNum < startCycle + windowCycles + 20)
			@(posedge CLOCK_50);
		for (int i = 0; i < `AXIS_COUNT; i++)
			readReg(regAddr_t'(REG_SPEED0 + i), (i == axis) ? 16'((nA + nB) / 2) : 16'd0);
		readReg(REG_WINDOW, 16'd4);
		readReg(REG_STATUS, expectedStatus());
		@(posedge CLOCK_50);
		encoders[axis].phaseB <= 1'b0;
	endtask

	task automatic beaconRound();
		int k;
		int a;
		int g;
		int b;
		k = randRange(1, 20);
		a = randRange(1, 8);
		g = randRange(1, `HOLD_TICKS - 2);
		b = randRange(1, 8);
		// sync clears the angle and flips turn
		@(posedge CLOCK_50);
		beaconSync <= 1'b1;
		repeat (4) @(posedge CLOCK_50);
		beaconSync <= 1'b0;
		repeat (4) @(posedge CLOCK_50);
		turnModel = ~turnModel;
		tickTurret(k);
		setSign(1'b1);
		tickTurret(a);
		// short dropout
		setSign(1'b0);
		tickTurret(g);
		setSign(1'b1);
		tickTurret(b);
		setSign(1'b0);
		tickTurret(`HOLD_TICKS);
		repeat (6) @(posedge CLOCK_50);
		readReg(REG_BEACON_START, 16'(k));
		readReg(REG_BEACON_END, 16'(k + a + g + b));
		readReg(REG_STATUS, expectedStatus());
	endtask

	initial begin
		logic [1:0] aux;
		reset = 1'b1;
		encoders = '0;
		beaconSign = 1'b0;
		beaconSync = 1'b0;
		turretA = 1'b0;
		limits = '0;
		startCord = 1'b0;
		keys = 2'b00;
		id = 1'b0;
		regWrite = '0;
		regReadAddr = REG_STATUS;
		readPending = 1'b0;
		expWord = '0;
		pinPending = 1'b0;
		expInt1 = 1'b1;
		expInt2 = 1'b1;
		expAux = 2'b00;
		dirModel = '0;
		turnModel = 1'b0;
		repeat (3) @(posedge CLOCK_50);
		reset <= 1'b0;

		// reset values, unused addresses too
		for (int a = 0; a < 16; a++)
			readReg(regAddr_t'(a), (a == REG_WINDOW) ? 16'(`WINDOW_DEFAULT) : 16'd0);
		checkPins(1'b1, 1'b1, 2'b00);

		repeat (speedRounds) speedRound();
		repeat (beaconRounds) beaconRound();

		// config, both interrupts on
		aux = 2'(randRange(1, 3));
		writeReg(REG_CONFIG, {10'b0, aux, 2'b0, 2'b11});
		readReg(REG_CONFIG, {10'b0, aux, 2'b0, 2'b11});
		@(posedge CLOCK_50);
		keys <= 2'(randRange(0, 3));
		repeat (4) @(posedge CLOCK_50);
		checkPins(keys[0], keys[1], aux);
		keys <= ~keys;
		repeat (4) @(posedge CLOCK_50);
		checkPins(keys[0], keys[1], aux);
		// only int1 enabled
		writeReg(REG_CONFIG, 16'h0001);
		// both keys low
		keys <= 2'b00;
		repeat (4) @(posedge CLOCK_50);
		checkPins(keys[0], 1'b1, 2'b00);

		// limit switches, cord and id into status, one input at a time
		for (int b = 0; b < 7; b++) begin
			@(posedge CLOCK_50);
			{limits, startCord, id} <= 7'(1 << b);
			repeat (4) @(posedge CLOCK_50);
			readReg(REG_STATUS, expectedStatus());
		end

		repeat (4) @(posedge CLOCK_50);
		$display("checks %0d errors %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// File: build.f
+incdir+hdl
hdl/robotSensePkg.sv
hdl/encoderChannel.sv
hdl/speedMeter.sv
hdl/beaconCapture.sv
hdl/sensorRegs.sv
hdl/robotSenseTop.sv
dv/robotSenseTb.sv

// File: Bender.yml
package:
  name: robot_sense

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/robotSensePkg.sv
      - hdl/encoderChannel.sv
      - hdl/speedMeter.sv
      - hdl/beaconCapture.sv
      - hdl/sensorRegs.sv
      - hdl/robotSenseTop.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/robotSenseTb.sv
